// ==== include/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// The RTL is written for a 32-bit word only

// Operand and result width
`define EXEC_DATA_W 32

// Command field width shared by all units
`define EXEC_CMD_W 5

// Unit select width
`define EXEC_UNIT_W 2

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f verilog.f \
		--top-module exec_unit_tb -o exec_unit_sim \
	&& ./obj_dir/exec_unit_sim \
	|| { echo "build or run returned an error"; exit 1; }

// ==== verif/exec_golden.txt ====
# unit cmd data_0 data_1 flag_we exp_data exp_flags
# exp_flags packs sf of cf pf zf from bit 4 down to bit 0
0 00 12345678 9abcdef0 1 12345678 00
0 01 12345678 9abcdef0 0 9abcdef0 10
0 02 0f0f0f0f 00000000 0 f0f0f0f0 10
0 03 00000000 00000000 0 ffffffff 12
0 04 ff00ff00 0f0f0f0f 0 0f000f00 00
0 05 ff00ff00 0f0f0f0f 0 ff0fff0f 12
0 06 ff00ff00 0f0f0f0f 0 f00ff00f 12
0 07 ff00ff00 0f0f0f0f 0 f0fff0ff 12
0 08 ff00ff00 0f0f0f0f 0 00f000f0 00
0 09 ff00ff00 0f0f0f0f 0 0ff00ff0 00
0 0a 00000000 0000001f 1 80000000 10
0 0b ffffffff 00000000 0 fffffffe 10
0 0c 10000001 00000000 0 80000008 10
0 0d 11223344 00000000 0 44332211 02
0 0e 00000100 00000008 0 00000001 02
0 0f 11223344 00000000 0 00000044 00
0 0f 11223344 00000001 0 00000033 02
0 0f 11223344 00000002 0 00000022 00
0 0f 11223344 00000003 0 00000011 02
0 10 aaaa5555 12348765 0 aaaa8765 12
0 11 aaaa5555 12348765 0 87655555 12
0 12 00000000 00008001 0 ffff8001 12
0 14 00000000 00008001 0 00008001 02
0 13 00000000 ffffffff 0 00000000 01
1 00 80000001 00000000 0 80000001 12
1 00 80000001 00000001 1 00000002 04
1 00 80000001 0000001f 0 80000000 10
1 01 80000001 00000001 0 40000000 04
1 01 80000001 0000001f 0 00000001 02
1 02 80000001 00000001 0 c0000000 14
1 02 80000001 0000001f 0 ffffffff 12
1 03 80000001 00000001 0 00000003 06
1 04 80000001 00000001 0 c0000000 14
1 03 80000001 0000001f 0 c0000000 10
1 04 80000001 00000000 0 80000001 12
2 00 7fffffff 00000001 1 80000000 18
2 00 ffffffff 00000001 1 00000000 05
2 01 00000000 00000001 1 ffffffff 16
2 01 80000000 00000001 0 7fffffff 0a
2 02 00000005 00000007 1 00000005 14
2 02 00000007 00000007 0 00000007 01
3 00 12345678 9abcdef0 0 00000000 00
2 00 00000001 00000001 1 00000002 00

// ==== verif/exec_unit_assertions.sv ====
`timescale 1ns/100ps

module exec_unit_assertions
(
	input logic       clock,
	input logic       rst,
	input logic       in_valid,
	input logic       flag_we,
	input logic       out_valid,
	input logic [4:0] cpu_flags
);

	// Result stage latency is exactly one cycle
	a_valid_follows: assert property (@(posedge clock) disable iff (rst)
		out_valid == $past(in_valid))
		else $error("out_valid does not follow in_valid by one cycle");

	a_reset_clears_valid: assert property (@(posedge clock)
		$past(rst) |-> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// Processor flags move only on a flag write
	a_flags_hold: assert property (@(posedge clock) disable iff (rst)
		(!$past(rst) && !$past(in_valid && flag_we)) |-> $stable(cpu_flags))
		else $error("processor flags changed without a flag write");

endmodule

bind exec_unit exec_unit_assertions assert_i
(
	.clock     (clock),
	.rst       (rst),
	.in_valid  (in_valid),
	.flag_we   (flag_we),
	.out_valid (out_valid),
	.cpu_flags ({flag_sf, flag_of, flag_cf, flag_pf, flag_zf})
);

// ==== verif/exec_unit_tb.sv ====
`timescale 1ns/100ps

`include "exec_config.svh"

module exec_unit_tb;

	typedef struct {
		logic [`EXEC_UNIT_W-1:0] unit;
		logic [`EXEC_CMD_W-1:0]  cmd;
		exec_pkg::data_t         data_0;
		exec_pkg::data_t         data_1;
		logic                    flag_we;
		exec_pkg::data_t         exp_data;
		exec_pkg::flags_t        exp_flags;
	} vector_t;

	logic                    clock = 1'b0;
	logic                    rst;
	logic                    in_valid;
	logic [`EXEC_UNIT_W-1:0] unit;
	logic [`EXEC_CMD_W-1:0]  cmd;
	logic [`EXEC_DATA_W-1:0] data_0;
	logic [`EXEC_DATA_W-1:0] data_1;
	logic                    flag_we;
	logic                    out_valid;
	logic [`EXEC_DATA_W-1:0] out_data;
	logic                    out_sf, out_of, out_cf, out_pf, out_zf;
	logic                    flag_sf, flag_of, flag_cf, flag_pf, flag_zf;

	vector_t          vectors[$];
	vector_t          pending[$]; // Issued and not yet checked
	vector_t          head;
	exec_pkg::flags_t shadow_flags = '0;
	int               checked = 0;
	int               cycle_count = 0;
	int               cycle_limit = 0;

	exec_unit dut_i
	(
		.clock     (clock),
		.rst       (rst),
		.in_valid  (in_valid),
		.unit      (unit),
		.cmd       (cmd),
		.data_0    (data_0),
		.data_1    (data_1),
		.flag_we   (flag_we),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_sf    (out_sf),
		.out_of    (out_of),
		.out_cf    (out_cf),
		.out_pf    (out_pf),
		.out_zf    (out_zf),
		.flag_sf   (flag_sf),
		.flag_of   (flag_of),
		.flag_cf   (flag_cf),
		.flag_pf   (flag_pf),
		.flag_zf   (flag_zf)
	);

	always #50 clock = ~clock; // 100 ns period

	task automatic check_data(input string name, input exec_pkg::data_t expected,
		input exec_pkg::data_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_flags(input string name, input exec_pkg::flags_t expected,
		input exec_pkg::flags_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          got;
		string       line;
		logic [31:0] f_unit;
		logic [31:0] f_cmd;
		logic [31:0] f_we;
		logic [31:0] f_flags;
		vector_t     v;
		fd = $fopen("verif/exec_golden.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verif/exec_golden.txt");
			$display("Simulation failed");
			$fatal(1, "missing golden file");
		end
		while (!$feof(fd))
		begin
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 0 && line[0] != "#")
			begin
				got = $sscanf(line, "%h %h %h %h %h %h %h", f_unit, f_cmd, v.data_0,
					v.data_1, f_we, v.exp_data, f_flags);
				if (got == 7)
				begin
					v.unit      = f_unit[`EXEC_UNIT_W-1:0];
					v.cmd       = f_cmd[`EXEC_CMD_W-1:0];
					v.flag_we   = f_we[0];
					v.exp_flags = exec_pkg::flags_t'(f_flags[4:0]);
					vectors.push_back(v);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_vector(input vector_t v);
		@(posedge clock);
		#1;
		in_valid = 1'b1;
		unit     = v.unit;
		cmd      = v.cmd;
		data_0   = v.data_0;
		data_1   = v.data_1;
		flag_we  = v.flag_we;
		pending.push_back(v);
	endtask

	// Outputs are sampled mid-cycle once they have settled
	always @(negedge clock)
	begin
		if (!rst && out_valid)
		begin
			if (pending.size() == 0)
			begin
				$display("out_valid was high with no instruction outstanding");
				$display("Simulation failed");
				$fatal(1, "unexpected result");
			end
			head = pending.pop_front();
			check_data("out_data", head.exp_data, out_data);
			check_flags("out_flags", head.exp_flags,
				exec_pkg::flags_t'({out_sf, out_of, out_cf, out_pf, out_zf}));
			if (head.flag_we)
				shadow_flags = head.exp_flags;
			check_flags("flag", shadow_flags,
				exec_pkg::flags_t'({flag_sf, flag_of, flag_cf, flag_pf, flag_zf}));
			checked++;
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: outputs never completed");
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial
	begin
		rst      = 1'b1;
		in_valid = 1'b0;
		unit     = '0;
		cmd      = '0;
		data_0   = '0;
		data_1   = '0;
		flag_we  = 1'b0;
		load_golden();
		cycle_limit = vectors.size() + 30;
		repeat (5) @(posedge clock);
		#1 rst = 1'b0;
		@(negedge clock);
		if (out_valid !== 1'b0)
		begin
			$display("out_valid was not low after reset");
			$display("Simulation failed");
			$fatal(1, "bad reset state");
		end
		check_data("out_data", '0, out_data);
		check_flags("out_flags", '0,
			exec_pkg::flags_t'({out_sf, out_of, out_cf, out_pf, out_zf}));
		check_flags("flag", '0,
			exec_pkg::flags_t'({flag_sf, flag_of, flag_cf, flag_pf, flag_zf}));
		foreach (vectors[i])
			apply_vector(vectors[i]); // One per cycle with no gaps
		@(posedge clock);
		#1 in_valid = 1'b0;
		flag_we = 1'b0;
		wait (checked == vectors.size());
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/exec_result_if.sv
verilog/exec_logic.sv
verilog/exec_shift.sv
verilog/exec_adder.sv
verilog/exec_flags_reg.sv
verilog/exec_unit.sv
verif/exec_unit_assertions.sv
verif/exec_unit_tb.sv

// ==== verilog/exec_adder.sv ====
`timescale 1ns/100ps

`include "exec_config.svh"

module exec_adder
(
	input  exec_pkg::add_cmd_t cmd,
	input  exec_pkg::data_t    data_0,
	input  exec_pkg::data_t    data_1,
	exec_result_if.unit        res
);

	localparam int MSB = `EXEC_DATA_W - 1;

	logic [`EXEC_DATA_W:0] sum_wide;
	logic [`EXEC_DATA_W:0] diff_wide;
	logic                  sum_of;
	logic                  diff_of;
	exec_pkg::data_t       result;
	exec_pkg::flags_t      flags;

	assign sum_wide  = {1'b0, data_0} + {1'b0, data_1};
	assign diff_wide = {1'b0, data_0} - {1'b0, data_1}; // Top bit is the unsigned borrow

	// Same-sign add or mixed-sign subtract that flips the sign
	assign sum_of  = (data_0[MSB] == data_1[MSB]) && (sum_wide[MSB] != data_0[MSB]);
	assign diff_of = (data_0[MSB] != data_1[MSB]) && (diff_wide[MSB] != data_0[MSB]);

	always_comb
	begin
		case (cmd)
			exec_pkg::ADD_SUB:
			begin
				result = diff_wide[MSB:0];
				flags  = exec_pkg::result_flags(diff_wide[MSB:0], diff_of, diff_wide[`EXEC_DATA_W]);
			end
			exec_pkg::ADD_CMP:
			begin
				result = data_0; // Operand passes through with the flags of the difference
				flags  = exec_pkg::result_flags(diff_wide[MSB:0], diff_of, diff_wide[`EXEC_DATA_W]);
			end
			default:
			begin
				result = sum_wide[MSB:0];
				flags  = exec_pkg::result_flags(sum_wide[MSB:0], sum_of, sum_wide[`EXEC_DATA_W]);
			end
		endcase
	end

	assign res.data  = result;
	assign res.flags = flags;

endmodule

// ==== verilog/exec_flags_reg.sv ====
`timescale 1ns/100ps

// Processor status flags read later by conditional branches
module exec_flags_reg
(
	input  logic             clock,
	input  logic             rst,
	input  logic             write,
	input  exec_pkg::flags_t flags_in,
	output exec_pkg::flags_t flags
);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			flags <= '0;
		end
		else if (write)
		begin
			flags <= flags_in; // Only instructions that ask for it
		end
	end

endmodule

// ==== verilog/exec_logic.sv ====
`timescale 1ns/100ps

module exec_logic
(
	input  exec_pkg::logic_cmd_t cmd,
	input  exec_pkg::data_t      data_0,
	input  exec_pkg::data_t      data_1,
	exec_result_if.unit          res
);

	exec_pkg::data_t result;
	exec_pkg::data_t bit_mask;

	assign bit_mask = exec_pkg::data_t'(1) << data_1[4:0]; // One-hot bit for set and clear

	always_comb
	begin
		case (cmd)
			exec_pkg::LOGIC_BUF0:
				result = data_0;
			exec_pkg::LOGIC_BUF1:
				result = data_1;
			exec_pkg::LOGIC_NOT0:
				result = ~data_0;
			exec_pkg::LOGIC_NOT1:
				result = ~data_1;
			exec_pkg::LOGIC_AND:
				result = data_0 & data_1;
			exec_pkg::LOGIC_OR:
				result = data_0 | data_1;
			exec_pkg::LOGIC_XOR:
				result = data_0 ^ data_1;
			exec_pkg::LOGIC_NAND:
				result = ~(data_0 & data_1);
			exec_pkg::LOGIC_NOR:
				result = ~(data_0 | data_1);
			exec_pkg::LOGIC_XNOR:
				result = ~(data_0 ^ data_1);
			exec_pkg::LOGIC_SETBIT:
				result = data_0 | bit_mask;
			exec_pkg::LOGIC_CLRBIT:
				result = data_0 & ~bit_mask;
			exec_pkg::LOGIC_BITREV:
				result = {<<{data_0}}; // Bit 31 lands in bit 0
			exec_pkg::LOGIC_BYTEREV:
				result = {<<8{data_0}};
			exec_pkg::LOGIC_GETBIT:
				result = exec_pkg::data_t'(data_0[data_1[4:0]]);
			exec_pkg::LOGIC_GETBYTE:
				result = exec_pkg::data_t'(data_0[data_1[1:0]*8 +: 8]); // Zero-extended byte
			exec_pkg::LOGIC_SETLO:
				result = {data_0[31:16], data_1[15:0]};
			exec_pkg::LOGIC_SETHI:
				result = {data_1[15:0], data_0[15:0]};
			exec_pkg::LOGIC_SEXT:
				result = {{16{data_1[15]}}, data_1[15:0]};
			exec_pkg::LOGIC_ZEXT:
				result = {16'h0000, data_1[15:0]};
			default:
				result = data_0; // Unlisted codes act as a buffer
		endcase
	end

	assign res.data  = result;
	assign res.flags = exec_pkg::result_flags(result, 1'b0, 1'b0); // No carry or overflow here

endmodule

// ==== verilog/exec_pkg.sv ====
`include "exec_config.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_W-1:0] data_t;

	// Select value 3 is reserved and gives zero
	typedef enum logic [`EXEC_UNIT_W-1:0] {
		UNIT_LOGIC = 2'd0,
		UNIT_SHIFT = 2'd1,
		UNIT_ADD   = 2'd2
	} unit_t;

	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} flags_t;

	typedef enum logic [`EXEC_CMD_W-1:0] {
		LOGIC_BUF0    = 5'h00,
		LOGIC_BUF1    = 5'h01,
		LOGIC_NOT0    = 5'h02,
		LOGIC_NOT1    = 5'h03,
		LOGIC_AND     = 5'h04,
		LOGIC_OR      = 5'h05,
		LOGIC_XOR     = 5'h06,
		LOGIC_NAND    = 5'h07,
		LOGIC_NOR     = 5'h08,
		LOGIC_XNOR    = 5'h09,
		LOGIC_SETBIT  = 5'h0A,
		LOGIC_CLRBIT  = 5'h0B,
		LOGIC_BITREV  = 5'h0C,
		LOGIC_BYTEREV = 5'h0D,
		LOGIC_GETBIT  = 5'h0E,
		LOGIC_GETBYTE = 5'h0F,
		LOGIC_SETLO   = 5'h10,
		LOGIC_SETHI   = 5'h11,
		LOGIC_SEXT    = 5'h12,
		LOGIC_ZEXT    = 5'h14
	} logic_cmd_t;

	typedef enum logic [`EXEC_CMD_W-1:0] {
		SHIFT_SLL = 5'h00,
		SHIFT_SRL = 5'h01,
		SHIFT_SRA = 5'h02,
		SHIFT_ROL = 5'h03,
		SHIFT_ROR = 5'h04
	} shift_cmd_t;

	typedef enum logic [`EXEC_CMD_W-1:0] {
		ADD_ADD = 5'h00,
		ADD_SUB = 5'h01,
		ADD_CMP = 5'h02
	} add_cmd_t;

	// Sign, parity and zero come from the value, of and cf from the unit
	function automatic flags_t result_flags(data_t value, logic of, logic cf);
		flags_t f;
		f.sf = value[`EXEC_DATA_W-1];
		f.of = of;
		f.cf = cf;
		f.pf = value[0];
		f.zf = (value == '0);
		return f;
	endfunction

endpackage

// ==== verilog/exec_result_if.sv ====
`timescale 1ns/100ps

// One unit's result on its way to the result stage
interface exec_result_if;

	exec_pkg::data_t  data;
	exec_pkg::flags_t flags;

	// Driven by a compute unit
	modport unit
	(
		output data,
		output flags
	);

	// Read by the result mux in the top level
	modport stage
	(
		input data,
		input flags
	);

endinterface

// ==== verilog/exec_shift.sv ====
`timescale 1ns/100ps

`include "exec_config.svh"

module exec_shift
(
	input  exec_pkg::shift_cmd_t cmd,
	input  exec_pkg::data_t      data_0,
	input  exec_pkg::data_t      data_1,
	exec_result_if.unit          res
);

	logic [4:0]                  amount;
	logic [`EXEC_DATA_W:0]       left_wide;
	logic [`EXEC_DATA_W:0]       right_wide;
	logic [`EXEC_DATA_W:0]       arith_wide;
	logic [2*`EXEC_DATA_W-1:0]   rol_wide;
	logic [2*`EXEC_DATA_W-1:0]   ror_wide;
	exec_pkg::data_t             result;
	logic                        carry;

	assign amount = data_1[4:0];

	// Extra bit catches the last bit shifted out
	assign left_wide  = {1'b0, data_0} << amount;
	assign right_wide = {data_0, 1'b0} >> amount;
	assign arith_wide = $signed({data_0, 1'b0}) >>> amount; // Sign fill

	// Doubling the word turns the rotate into a plain shift
	assign rol_wide = {data_0, data_0} << amount;
	assign ror_wide = {data_0, data_0} >> amount;

	always_comb
	begin
		carry = 1'b0;
		case (cmd)
			exec_pkg::SHIFT_SLL:
			begin
				result = left_wide[`EXEC_DATA_W-1:0];
				carry  = left_wide[`EXEC_DATA_W];
			end
			exec_pkg::SHIFT_SRL:
			begin
				result = right_wide[`EXEC_DATA_W:1];
				carry  = right_wide[0];
			end
			exec_pkg::SHIFT_SRA:
			begin
				result = arith_wide[`EXEC_DATA_W:1];
				carry  = arith_wide[0];
			end
			exec_pkg::SHIFT_ROL:
			begin
				result = rol_wide[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
				carry  = (amount != '0) & result[0]; // Last bit out wraps to bit 0
			end
			exec_pkg::SHIFT_ROR:
			begin
				result = ror_wide[`EXEC_DATA_W-1:0];
				carry  = (amount != '0) & result[`EXEC_DATA_W-1];
			end
			default:
				result = data_0;
		endcase
	end

	assign res.data  = result;
	assign res.flags = exec_pkg::result_flags(result, 1'b0, carry);

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/100ps

`include "exec_config.svh"

module exec_unit
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    in_valid,
	input  logic [`EXEC_UNIT_W-1:0] unit,
	input  logic [`EXEC_CMD_W-1:0]  cmd,
	input  logic [`EXEC_DATA_W-1:0] data_0,
	input  logic [`EXEC_DATA_W-1:0] data_1,
	input  logic                    flag_we,
	output logic                    out_valid,
	output logic [`EXEC_DATA_W-1:0] out_data,
	output logic                    out_sf,
	output logic                    out_of,
	output logic                    out_cf,
	output logic                    out_pf,
	output logic                    out_zf,
	output logic                    flag_sf,
	output logic                    flag_of,
	output logic                    flag_cf,
	output logic                    flag_pf,
	output logic                    flag_zf
);

	exec_result_if logic_res ();
	exec_result_if shift_res ();
	exec_result_if add_res ();

	exec_pkg::data_t  sel_data;
	exec_pkg::flags_t sel_flags;
	exec_pkg::flags_t out_flags;
	exec_pkg::flags_t cpu_flags;

	exec_logic logic_i
	(
		.cmd    (exec_pkg::logic_cmd_t'(cmd)),
		.data_0 (data_0),
		.data_1 (data_1),
		.res    (logic_res.unit)
	);

	exec_shift shift_i
	(
		.cmd    (exec_pkg::shift_cmd_t'(cmd)),
		.data_0 (data_0),
		.data_1 (data_1),
		.res    (shift_res.unit)
	);

	exec_adder adder_i
	(
		.cmd    (exec_pkg::add_cmd_t'(cmd)),
		.data_0 (data_0),
		.data_1 (data_1),
		.res    (add_res.unit)
	);

	always_comb
	begin
		case (exec_pkg::unit_t'(unit))
			exec_pkg::UNIT_LOGIC:
			begin
				sel_data  = logic_res.data;
				sel_flags = logic_res.flags;
			end
			exec_pkg::UNIT_SHIFT:
			begin
				sel_data  = shift_res.data;
				sel_flags = shift_res.flags;
			end
			exec_pkg::UNIT_ADD:
			begin
				sel_data  = add_res.data;
				sel_flags = add_res.flags;
			end
			default:
			begin
				sel_data  = '0; // Reserved select
				sel_flags = '0;
			end
		endcase
	end

	// Result stage holds the last result while idle
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_data  <= '0;
			out_flags <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
			begin
				out_data  <= sel_data;
				out_flags <= sel_flags;
			end
		end
	end

	exec_flags_reg flags_i
	(
		.clock    (clock),
		.rst      (rst),
		.write    (in_valid & flag_we),
		.flags_in (sel_flags),
		.flags    (cpu_flags)
	);

	assign out_sf  = out_flags.sf;
	assign out_of  = out_flags.of;
	assign out_cf  = out_flags.cf;
	assign out_pf  = out_flags.pf;
	assign out_zf  = out_flags.zf;

	assign flag_sf = cpu_flags.sf;
	assign flag_of = cpu_flags.of;
	assign flag_cf = cpu_flags.cf;
	assign flag_pf = cpu_flags.pf;
	assign flag_zf = cpu_flags.zf;

endmodule
